//--- design/lsq_pkg.sv
package lsq_pkg;

  // ========================================
  // widths
  // ========================================

  // byte address width
  parameter int ADDR_W = 16;
  // one memory doubleword
  parameter int DATA_W = 64;

  // ========================================
  // access size and word view
  // ========================================

  // access size, naturally aligned
  typedef enum logic [1:0] {
    MEM_BYTE   = 2'd0,
    MEM_HALF   = 2'd1,
    MEM_WORD   = 2'd2,
    MEM_DOUBLE = 2'd3
  } mem_size_e;

  // one memory word, whole or by byte lane
  typedef union packed {
    logic [DATA_W-1:0] dword;
    logic [7:0][7:0]   lanes;
  } mem_word_u;

  // lane enables for a size at a byte offset
  // offset assumed aligned to the size
  function automatic logic [7:0] size_mask(input mem_size_e size, input logic [2:0] off);
    case (size)
      MEM_BYTE: size_mask = 8'b0000_0001 << off;
      MEM_HALF: size_mask = 8'b0000_0011 << off;
      MEM_WORD: size_mask = 8'b0000_1111 << off;
      default:  size_mask = 8'b1111_1111;
    endcase
  endfunction

endpackage

//--- design/store_queue.sv
`timescale 1ns/1ns

module store_queue #(
  parameter int SQ_DEPTH  = 8,
  parameter int ROB_IDX_W = 5
) (
  input  logic                          clock,
  input  logic                          reset,
  // dispatch
  input  logic                          enq_valid_i,
  input  lsq_pkg::mem_size_e            enq_size_i,
  input  logic [ROB_IDX_W-1:0]          enq_rob_idx_i,
  // execute fill
  input  logic                          exec_valid_i,
  input  logic [ROB_IDX_W-1:0]          exec_rob_idx_i,
  input  logic [lsq_pkg::ADDR_W-1:0]    exec_addr_i,
  input  logic [lsq_pkg::DATA_W-1:0]    exec_data_i,
  // rob head tag
  input  logic [ROB_IDX_W-1:0]          rob_head_i,
  // arbiter grant for the drain
  input  logic                          st_gnt_i,
  output logic                          sq_full_o,
  output logic [$clog2(SQ_DEPTH+1)-1:0] free_slots_o,
  output logic                          store_ready_valid_o,
  output logic [ROB_IDX_W-1:0]          store_ready_idx_o,
  // drain request toward memory
  output logic                          st_req_o,
  output logic [lsq_pkg::ADDR_W-1:0]    st_addr_o,
  output lsq_pkg::mem_size_e            st_size_o,
  output logic [lsq_pkg::DATA_W-1:0]    st_data_o
);

  localparam int IDX_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(SQ_DEPTH+1);

  // ========================================
  // entry array
  // ========================================

  // per-entry control flags
  logic [SQ_DEPTH-1:0]       ent_valid;
  logic [SQ_DEPTH-1:0]       ent_filled;
  logic [SQ_DEPTH-1:0]       ent_committed;
  // per-entry payload
  lsq_pkg::mem_size_e        ent_size [SQ_DEPTH];
  logic [ROB_IDX_W-1:0]      ent_tag  [SQ_DEPTH];
  logic [lsq_pkg::ADDR_W-1:0] ent_addr [SQ_DEPTH];
  logic [lsq_pkg::DATA_W-1:0] ent_data [SQ_DEPTH];

  // ring pointers and occupancy
  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] tail;
  logic [CNT_W-1:0] count;

  // per-entry tag matches
  logic [SQ_DEPTH-1:0] fill_hit;
  logic [SQ_DEPTH-1:0] commit_hit;
  logic                commit_any;

  logic do_enq;
  logic do_pop;

  // wrap at the last slot, depth need not be a power of two
  function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] ptr);
    if (ptr == IDX_W'(SQ_DEPTH-1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + 1'b1;
    end
  endfunction

  assign sq_full_o    = (count == CNT_W'(SQ_DEPTH));
  assign free_slots_o = CNT_W'(SQ_DEPTH) - count;

  // enqueue while full is dropped
  assign do_enq = enq_valid_i && !sq_full_o;
  assign do_pop = st_req_o && st_gnt_i;

  // ========================================
  // tag search
  // ========================================

  always_comb begin
    commit_any = 1'b0;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      // execute result, tags in flight are unique
      fill_hit[i]   = exec_valid_i && ent_valid[i] && (ent_tag[i] == exec_rob_idx_i);
      // entry named by the rob head
      commit_hit[i] = ent_valid[i] && (ent_tag[i] == rob_head_i);
      commit_any    = commit_any | commit_hit[i];
    end
  end

  // ========================================
  // control state
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      head                <= '0;
      tail                <= '0;
      count               <= '0;
      ent_valid           <= '0;
      ent_filled          <= '0;
      ent_committed       <= '0;
      store_ready_valid_o <= 1'b0;
      store_ready_idx_o   <= '0;
    end else begin
      // occupancy, enq plus pop leaves it alone
      if (do_enq && !do_pop) begin
        count <= count + 1'b1;
      end else if (!do_enq && do_pop) begin
        count <= count - 1'b1;
      end

      // flags from execute and commit
      for (int i = 0; i < SQ_DEPTH; i++) begin
        if (fill_hit[i]) begin
          ent_filled[i] <= 1'b1;
        end
        if (commit_hit[i]) begin
          ent_committed[i] <= 1'b1;
        end
      end

      // ready report to the rob, one cycle behind the match
      store_ready_valid_o <= commit_any;
      store_ready_idx_o   <= commit_any ? rob_head_i : '0;

      // pop the head on grant
      if (do_pop) begin
        ent_valid[head]     <= 1'b0;
        ent_filled[head]    <= 1'b0;
        ent_committed[head] <= 1'b0;
        head                <= next_ptr(head);
      end

      // new entry at the tail
      // never the head slot here, count is neither 0 nor full
      if (do_enq) begin
        ent_valid[tail]     <= 1'b1;
        ent_filled[tail]    <= 1'b0;
        ent_committed[tail] <= 1'b0;
        tail                <= next_ptr(tail);
      end
    end
  end

  // ========================================
  // payload
  // ========================================

  always_ff @(posedge clock) begin
    // size and tag at dispatch
    if (do_enq) begin
      ent_size[tail] <= enq_size_i;
      ent_tag[tail]  <= enq_rob_idx_i;
    end
    // address and data later from execute
    for (int i = 0; i < SQ_DEPTH; i++) begin
      if (fill_hit[i]) begin
        ent_addr[i] <= exec_addr_i;
        ent_data[i] <= exec_data_i;
      end
    end
  end

  // head offered once committed and filled
  assign st_req_o  = ent_valid[head] && ent_committed[head] && ent_filled[head];
  assign st_addr_o = ent_addr[head];
  assign st_size_o = ent_size[head];
  assign st_data_o = ent_data[head];

endmodule

//--- design/load_port.sv
`timescale 1ns/1ns

module load_port (
  input  logic                       clock,
  input  logic                       reset,
  // load issue
  input  logic                       load_valid_i,
  input  logic [lsq_pkg::ADDR_W-1:0] load_addr_i,
  input  lsq_pkg::mem_size_e         load_size_i,
  // memory side
  input  logic                       ld_gnt_i,
  input  logic [lsq_pkg::DATA_W-1:0] mem_rdata_i,
  output logic                       load_ready_o,
  output logic                       ld_req_o,
  output logic [lsq_pkg::ADDR_W-1:0] ld_addr_o,
  output lsq_pkg::mem_size_e         ld_size_o,
  // result
  output logic                       load_resp_valid_o,
  output logic [lsq_pkg::DATA_W-1:0] load_resp_data_o
);

  // held load
  logic                       busy;
  logic                       resp_pend;
  logic [lsq_pkg::ADDR_W-1:0] ld_addr_q;
  lsq_pkg::mem_size_e         ld_size_q;

  // returned word and its kept lanes
  lsq_pkg::mem_word_u rd_word;
  lsq_pkg::mem_word_u kept_word;
  logic [7:0]         lane_mask;

  // ========================================
  // one-entry buffer
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      busy      <= 1'b0;
      resp_pend <= 1'b0;
    end else if (!busy) begin
      busy <= load_valid_i;
    end else if (resp_pend) begin
      // response cycle done, back to idle
      busy      <= 1'b0;
      resp_pend <= 1'b0;
    end else if (ld_gnt_i) begin
      // read happens at this edge, data next cycle
      resp_pend <= 1'b1;
    end
  end

  // capture on acceptance only
  always_ff @(posedge clock) begin
    if (load_valid_i && !busy) begin
      ld_addr_q <= load_addr_i;
      ld_size_q <= load_size_i;
    end
  end

  assign load_ready_o = !busy;
  // level request until granted
  assign ld_req_o     = busy && !resp_pend;
  assign ld_addr_o    = ld_addr_q;
  assign ld_size_o    = ld_size_q;

  // ========================================
  // lane select and zero-extend
  // ========================================

  always_comb begin
    rd_word.dword = mem_rdata_i;
    lane_mask     = lsq_pkg::size_mask(ld_size_q, ld_addr_q[2:0]);
    for (int i = 0; i < 8; i++) begin
      kept_word.lanes[i] = lane_mask[i] ? rd_word.lanes[i] : 8'h00;
    end
    // shift the kept lanes down to bit 0
    load_resp_data_o = kept_word.dword >> {ld_addr_q[2:0], 3'b000};
  end

  assign load_resp_valid_o = resp_pend;

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                       clock,
  input  logic                       reset,
  // store drain
  input  logic                       st_req_i,
  input  logic [lsq_pkg::ADDR_W-1:0] st_addr_i,
  input  lsq_pkg::mem_size_e         st_size_i,
  input  logic [lsq_pkg::DATA_W-1:0] st_data_i,
  // load port
  input  logic                       ld_req_i,
  input  logic [lsq_pkg::ADDR_W-1:0] ld_addr_i,
  input  lsq_pkg::mem_size_e         ld_size_i,
  output logic                       st_gnt_o,
  output logic                       ld_gnt_o,
  // single memory port
  output logic                       mem_en_o,
  output logic                       mem_we_o,
  output logic [lsq_pkg::ADDR_W-1:0] mem_addr_o,
  output lsq_pkg::mem_size_e         mem_size_o,
  output logic [lsq_pkg::DATA_W-1:0] mem_wdata_o
);

  // last winner, 1 means the load side
  logic last_ld;

  // ========================================
  // round robin between two
  // ========================================

  // alone wins, on conflict the side not granted last time
  assign st_gnt_o = st_req_i && (!ld_req_i || last_ld);
  assign ld_gnt_o = ld_req_i && (!st_req_i || !last_ld);

  always_ff @(posedge clock) begin
    if (reset) begin
      last_ld <= 1'b0;
    end else if (st_gnt_o) begin
      last_ld <= 1'b0;
    end else if (ld_gnt_o) begin
      last_ld <= 1'b1;
    end
  end

  // winner's fields to memory
  assign mem_en_o    = st_gnt_o || ld_gnt_o;
  // only the store side writes
  assign mem_we_o    = st_gnt_o;
  assign mem_addr_o  = st_gnt_o ? st_addr_i : ld_addr_i;
  assign mem_size_o  = st_gnt_o ? st_size_i : ld_size_i;
  assign mem_wdata_o = st_data_i;

endmodule

//--- design/data_mem.sv
`timescale 1ns/1ns

module data_mem #(
  parameter int MEM_WORDS = 64
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       mem_en_i,
  input  logic                       mem_we_i,
  input  logic [lsq_pkg::ADDR_W-1:0] mem_addr_i,
  input  lsq_pkg::mem_size_e         mem_size_i,
  input  logic [lsq_pkg::DATA_W-1:0] mem_wdata_i,
  output logic [lsq_pkg::DATA_W-1:0] mem_rdata_o
);

  localparam int WIDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  // doubleword storage
  lsq_pkg::mem_word_u mem_q [MEM_WORDS];

  // word index, upper address bits dropped
  logic [WIDX_W-1:0]  word_idx;
  logic [2:0]         byte_off;
  logic [7:0]         wr_mask;
  lsq_pkg::mem_word_u wr_word;

  assign word_idx = mem_addr_i[WIDX_W+2:3];
  assign byte_off = mem_addr_i[2:0];
  assign wr_mask  = lsq_pkg::size_mask(mem_size_i, byte_off);
  // low bytes moved up to the lane offset
  assign wr_word.dword = mem_wdata_i << {byte_off, 3'b000};

  // ========================================
  // write port, cleared at reset
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w].dword <= '0;
      end
    end else if (mem_en_i && mem_we_i) begin
      // enabled lanes only
      for (int i = 0; i < 8; i++) begin
        if (wr_mask[i]) begin
          mem_q[word_idx].lanes[i] <= wr_word.lanes[i];
        end
      end
    end
  end

  // registered read of the whole word
  always_ff @(posedge clock) begin
    if (mem_en_i && !mem_we_i) begin
      mem_rdata_o <= mem_q[word_idx].dword;
    end
  end

endmodule

//--- design/lsq_top.sv
`timescale 1ns/1ns

module lsq_top #(
  parameter int SQ_DEPTH  = 8,
  parameter int ROB_IDX_W = 5,
  parameter int MEM_WORDS = 64
) (
  input  logic                          clock,
  input  logic                          reset,
  // dispatch
  input  logic                          enq_valid_i,
  input  lsq_pkg::mem_size_e            enq_size_i,
  input  logic [ROB_IDX_W-1:0]          enq_rob_idx_i,
  output logic                          sq_full_o,
  output logic [$clog2(SQ_DEPTH+1)-1:0] free_slots_o,
  // execute
  input  logic                          exec_valid_i,
  input  logic [ROB_IDX_W-1:0]          exec_rob_idx_i,
  input  logic [lsq_pkg::ADDR_W-1:0]    exec_addr_i,
  input  logic [lsq_pkg::DATA_W-1:0]    exec_data_i,
  // rob
  input  logic [ROB_IDX_W-1:0]          rob_head_i,
  output logic                          store_ready_valid_o,
  output logic [ROB_IDX_W-1:0]          store_ready_idx_o,
  // loads
  input  logic                          load_valid_i,
  input  logic [lsq_pkg::ADDR_W-1:0]    load_addr_i,
  input  lsq_pkg::mem_size_e            load_size_i,
  output logic                          load_ready_o,
  output logic                          load_resp_valid_o,
  output logic [lsq_pkg::DATA_W-1:0]    load_resp_data_o
);

  // ========================================
  // internal nets
  // ========================================

  // store drain to arbiter
  logic                       st_req;
  logic                       st_gnt;
  logic [lsq_pkg::ADDR_W-1:0] st_addr;
  lsq_pkg::mem_size_e         st_size;
  logic [lsq_pkg::DATA_W-1:0] st_data;
  // load port to arbiter
  logic                       ld_req;
  logic                       ld_gnt;
  logic [lsq_pkg::ADDR_W-1:0] ld_addr;
  lsq_pkg::mem_size_e         ld_size;
  // arbiter to memory
  logic                       mem_en;
  logic                       mem_we;
  logic [lsq_pkg::ADDR_W-1:0] mem_addr;
  lsq_pkg::mem_size_e         mem_size;
  logic [lsq_pkg::DATA_W-1:0] mem_wdata;
  logic [lsq_pkg::DATA_W-1:0] mem_rdata;

  store_queue #(
    .SQ_DEPTH  (SQ_DEPTH),
    .ROB_IDX_W (ROB_IDX_W)
  ) u_store_queue (
    .clock               (clock),
    .reset               (reset),
    .enq_valid_i         (enq_valid_i),
    .enq_size_i          (enq_size_i),
    .enq_rob_idx_i       (enq_rob_idx_i),
    .exec_valid_i        (exec_valid_i),
    .exec_rob_idx_i      (exec_rob_idx_i),
    .exec_addr_i         (exec_addr_i),
    .exec_data_i         (exec_data_i),
    .rob_head_i          (rob_head_i),
    .st_gnt_i            (st_gnt),
    .sq_full_o           (sq_full_o),
    .free_slots_o        (free_slots_o),
    .store_ready_valid_o (store_ready_valid_o),
    .store_ready_idx_o   (store_ready_idx_o),
    .st_req_o            (st_req),
    .st_addr_o           (st_addr),
    .st_size_o           (st_size),
    .st_data_o           (st_data)
  );

  load_port u_load_port (
    .clock             (clock),
    .reset             (reset),
    .load_valid_i      (load_valid_i),
    .load_addr_i       (load_addr_i),
    .load_size_i       (load_size_i),
    .ld_gnt_i          (ld_gnt),
    .mem_rdata_i       (mem_rdata),
    .load_ready_o      (load_ready_o),
    .ld_req_o          (ld_req),
    .ld_addr_o         (ld_addr),
    .ld_size_o         (ld_size),
    .load_resp_valid_o (load_resp_valid_o),
    .load_resp_data_o  (load_resp_data_o)
  );

  mem_arbiter u_mem_arbiter (
    .clock       (clock),
    .reset       (reset),
    .st_req_i    (st_req),
    .st_addr_i   (st_addr),
    .st_size_i   (st_size),
    .st_data_i   (st_data),
    .ld_req_i    (ld_req),
    .ld_addr_i   (ld_addr),
    .ld_size_i   (ld_size),
    .st_gnt_o    (st_gnt),
    .ld_gnt_o    (ld_gnt),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_size_o  (mem_size),
    .mem_wdata_o (mem_wdata)
  );

  data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_data_mem (
    .clock       (clock),
    .reset       (reset),
    .mem_en_i    (mem_en),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_size_i  (mem_size),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD = 10
) (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #(PERIOD/2) clock_o = ~clock_o;
  end

  // reset held for two rising edges
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clock_o);
    reset_o <= 1'b0;
  end

endmodule

//--- testbench/lsq_props.sv
`timescale 1ns/1ns

module lsq_props (
  input logic clock,
  input logic reset,
  input logic st_req_i,
  input logic ld_req_i,
  input logic st_gnt_i,
  input logic ld_gnt_i,
  input logic mem_en_i
);

  // one memory port, one winner
  grant_onehot: assert property (@(posedge clock) disable iff (reset)
    !(st_gnt_i && ld_gnt_i)) else $error("both grants high");

  // no grant without its own request
  st_grant_req: assert property (@(posedge clock) disable iff (reset)
    st_gnt_i |-> st_req_i) else $error("store grant without request");
  ld_grant_req: assert property (@(posedge clock) disable iff (reset)
    ld_gnt_i |-> ld_req_i) else $error("load grant without request");

  // conflict goes to the side that lost last time
  alt_after_st: assert property (@(posedge clock) disable iff (reset)
    (st_req_i && ld_req_i && $past(st_gnt_i)) |-> ld_gnt_i)
    else $error("store won twice in a row under conflict");
  alt_after_ld: assert property (@(posedge clock) disable iff (reset)
    (st_req_i && ld_req_i && $past(ld_gnt_i)) |-> st_gnt_i)
    else $error("load won twice in a row under conflict");

  // enable is exactly a grant
  en_is_grant: assert property (@(posedge clock) disable iff (reset)
    mem_en_i == (st_gnt_i || ld_gnt_i)) else $error("memory enable differs from grants");

endmodule

bind mem_arbiter lsq_props u_lsq_props (
  .clock    (clock),
  .reset    (reset),
  .st_req_i (st_req_i),
  .ld_req_i (ld_req_i),
  .st_gnt_i (st_gnt_o),
  .ld_gnt_i (ld_gnt_o),
  .mem_en_i (mem_en_o)
);

//--- testbench/lsq_tb.sv
`timescale 1ns/1ns

module lsq_tb;

  localparam int SQ_DEPTH   = 8;
  localparam int ROB_IDX_W  = 5;
  localparam int MEM_WORDS  = 64;
  localparam int CLK_PERIOD = 10;
  localparam int CNT_W      = $clog2(SQ_DEPTH+1);
  // test lengths
  localparam int STREAM_BATCHES = 4;
  localparam int MIXED_BATCHES  = 3;
  localparam int MIXED_LOADS    = 12;
  // watchdog budget, one op per enqueue, fill or load
  localparam int NUM_OPS    = 1 + 3 * STREAM_BATCHES * SQ_DEPTH + 2 * SQ_DEPTH + 1
                              + MIXED_BATCHES * (3 * SQ_DEPTH + MIXED_LOADS);
  localparam int OP_CYCLES  = 40;

  logic clock;
  logic reset;

  // dut inputs
  logic                       enq_valid;
  lsq_pkg::mem_size_e         enq_size;
  logic [ROB_IDX_W-1:0]       enq_rob_idx;
  logic                       exec_valid;
  logic [ROB_IDX_W-1:0]       exec_rob_idx;
  logic [lsq_pkg::ADDR_W-1:0] exec_addr;
  logic [lsq_pkg::DATA_W-1:0] exec_data;
  logic [ROB_IDX_W-1:0]       rob_head;
  logic                       load_valid;
  logic [lsq_pkg::ADDR_W-1:0] load_addr;
  lsq_pkg::mem_size_e         load_size;

  // dut outputs
  logic                       sq_full_o;
  logic [CNT_W-1:0]           free_slots_o;
  logic                       store_ready_valid_o;
  logic [ROB_IDX_W-1:0]       store_ready_idx_o;
  logic                       load_ready_o;
  logic                       load_resp_valid_o;
  logic [lsq_pkg::DATA_W-1:0] load_resp_data_o;

  // ========================================
  // model state
  // ========================================

  logic [7:0]                 model_mem [MEM_WORDS*8];
  // stores in the queue, program order
  logic [lsq_pkg::ADDR_W-1:0] pend_addr [$];
  lsq_pkg::mem_size_e         pend_size [$];
  logic [lsq_pkg::DATA_W-1:0] pend_data [$];
  // current batch
  logic [lsq_pkg::ADDR_W-1:0] b_addr [SQ_DEPTH];
  lsq_pkg::mem_size_e         b_size [SQ_DEPTH];
  logic [lsq_pkg::DATA_W-1:0] b_data [SQ_DEPTH];
  logic [ROB_IDX_W-1:0]       b_tag  [SQ_DEPTH];
  // phase 1 addresses for read back
  logic [lsq_pkg::ADDR_W-1:0] wr_addr [$];
  lsq_pkg::mem_size_e         wr_size [$];

  logic [31:0]                rng_state = 32'd88046;
  logic [ROB_IDX_W-1:0]       next_tag;
  logic [CNT_W-1:0]           prev_free;
  // current head tag already seen ready
  logic                       head_reported;
  int                         reported_cnt;
  int                         applied_cnt;
  int                         accepted_cnt;
  int                         resp_cnt;
  logic                       resp_got;
  logic [lsq_pkg::DATA_W-1:0] resp_data;
  int                         err_val;
  int                         err_other;

  clock_gen #(.PERIOD(CLK_PERIOD)) u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  lsq_top #(
    .SQ_DEPTH  (SQ_DEPTH),
    .ROB_IDX_W (ROB_IDX_W),
    .MEM_WORDS (MEM_WORDS)
  ) uut (
    .clock               (clock),
    .reset               (reset),
    .enq_valid_i         (enq_valid),
    .enq_size_i          (enq_size),
    .enq_rob_idx_i       (enq_rob_idx),
    .sq_full_o           (sq_full_o),
    .free_slots_o        (free_slots_o),
    .exec_valid_i        (exec_valid),
    .exec_rob_idx_i      (exec_rob_idx),
    .exec_addr_i         (exec_addr),
    .exec_data_i         (exec_data),
    .rob_head_i          (rob_head),
    .store_ready_valid_o (store_ready_valid_o),
    .store_ready_idx_o   (store_ready_idx_o),
    .load_valid_i        (load_valid),
    .load_addr_i         (load_addr),
    .load_size_i         (load_size),
    .load_ready_o        (load_ready_o),
    .load_resp_valid_o   (load_resp_valid_o),
    .load_resp_data_o    (load_resp_data_o)
  );

  // ========================================
  // helpers
  // ========================================

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int rand_below(input int n);
    return int'(xorshift32() % 32'(n));
  endfunction

  // aligned address inside a word range
  function automatic logic [lsq_pkg::ADDR_W-1:0] rand_addr(input int base_word, input int span,
                                                          input lsq_pkg::mem_size_e size);
    int word;
    int off;
    word = base_word + rand_below(span);
    off  = rand_below(8) & ~((1 << int'(size)) - 1);
    return lsq_pkg::ADDR_W'(word * 8 + off);
  endfunction

  // zero-extended bytes from the model
  function automatic logic [lsq_pkg::DATA_W-1:0] model_read(input logic [lsq_pkg::ADDR_W-1:0] addr,
                                                           input lsq_pkg::mem_size_e size);
    logic [lsq_pkg::DATA_W-1:0] val;
    int                         base;
    val  = '0;
    base = int'(addr) % (MEM_WORDS * 8);
    for (int b = 0; b < (1 << int'(size)); b++) begin
      val[8*b +: 8] = model_mem[base + b];
    end
    return val;
  endfunction

  task automatic apply_store(input logic [lsq_pkg::ADDR_W-1:0] addr,
                             input lsq_pkg::mem_size_e size,
                             input logic [lsq_pkg::DATA_W-1:0] data);
    int base;
    base = int'(addr) % (MEM_WORDS * 8);
    for (int b = 0; b < (1 << int'(size)); b++) begin
      model_mem[base + b] = data[8*b +: 8];
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      err_val++;
    end
  endtask

  // ========================================
  // one cycle, rob emulation and monitor
  // ========================================

  task automatic step();
    @(negedge clock);
    // ready report for the current head, counted once
    if (store_ready_valid_o) begin
      check_val("store_ready_idx_o", 64'(store_ready_idx_o), 64'(rob_head));
      if (store_ready_idx_o == rob_head && !head_reported) begin
        head_reported = 1'b1;
        reported_cnt++;
      end
    end
    // rob head moves on after a random pause
    // so later stores are filled before they commit
    if (head_reported && rand_below(4) == 0) begin
      rob_head      = rob_head + 1'b1;
      head_reported = 1'b0;
    end
    // a rise in free slots is one finished drain
    if (free_slots_o > prev_free) begin
      assert (pend_addr.size() > 0 && reported_cnt > applied_cnt) else begin
        $display("a store drained before its ROB tag was reported ready");
        err_other++;
      end
      if (pend_addr.size() > 0) begin
        apply_store(pend_addr[0], pend_size[0], pend_data[0]);
        void'(pend_addr.pop_front());
        void'(pend_size.pop_front());
        void'(pend_data.pop_front());
        applied_cnt++;
      end
    end
    prev_free = free_slots_o;
    check_val("free_slots_o", 64'(free_slots_o), 64'(SQ_DEPTH - pend_addr.size()));
    check_val("sq_full_o", 64'(sq_full_o), 64'(pend_addr.size() == SQ_DEPTH));
    if (load_resp_valid_o) begin
      resp_got  = 1'b1;
      resp_data = load_resp_data_o;
      resp_cnt++;
    end
  endtask

  task automatic check_idle();
    check_val("load_ready_o", 64'(load_ready_o), 64'd1);
    check_val("free_slots_o", 64'(free_slots_o), 64'(SQ_DEPTH));
    check_val("sq_full_o", 64'(sq_full_o), 64'd0);
    check_val("store_ready_valid_o", 64'(store_ready_valid_o), 64'd0);
    check_val("load_resp_valid_o", 64'(load_resp_valid_o), 64'd0);
    check_val("st_gnt", 64'(uut.st_gnt), 64'd0);
    check_val("ld_gnt", 64'(uut.ld_gnt), 64'd0);
  endtask

  // ========================================
  // stimulus tasks
  // ========================================

  // random batch entered at dispatch, no fill yet
  task automatic enqueue_batch(input int n, input int base_word, input int span);
    for (int i = 0; i < n; i++) begin
      b_size[i]   = lsq_pkg::mem_size_e'(rand_below(4));
      b_addr[i]   = rand_addr(base_word, span, b_size[i]);
      b_data[i]   = {xorshift32(), xorshift32()};
      b_tag[i]    = next_tag;
      enq_valid   = 1'b1;
      enq_size    = b_size[i];
      enq_rob_idx = next_tag;
      pend_addr.push_back(b_addr[i]);
      pend_size.push_back(b_size[i]);
      pend_data.push_back(b_data[i]);
      next_tag = next_tag + 1'b1;
      step();
    end
    enq_valid = 1'b0;
  endtask

  // execute results in shuffled tag order
  task automatic fill_batch(input int n);
    int perm [SQ_DEPTH];
    int j;
    int t;
    for (int i = 0; i < n; i++) begin
      perm[i] = i;
    end
    for (int i = n - 1; i > 0; i--) begin
      j       = rand_below(i + 1);
      t       = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
    for (int i = 0; i < n; i++) begin
      exec_valid   = 1'b1;
      exec_rob_idx = b_tag[perm[i]];
      exec_addr    = b_addr[perm[i]];
      exec_data    = b_data[perm[i]];
      step();
    end
    exec_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (pend_addr.size() != 0) begin
      step();
    end
    repeat (2) step();
  endtask

  task automatic do_load(input logic [lsq_pkg::ADDR_W-1:0] addr, input lsq_pkg::mem_size_e size);
    logic [lsq_pkg::DATA_W-1:0] exp;
    while (!load_ready_o) begin
      step();
    end
    // target bytes have no pending store
    exp        = model_read(addr, size);
    resp_got   = 1'b0;
    load_valid = 1'b1;
    load_addr  = addr;
    load_size  = size;
    step();
    load_valid = 1'b0;
    accepted_cnt++;
    check_val("load_ready_o", 64'(load_ready_o), 64'd0);
    while (!resp_got) begin
      step();
    end
    check_val("load_resp_data_o", resp_data, exp);
    check_val("load_resp_count", 64'(resp_cnt), 64'(accepted_cnt));
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    enq_valid     = 1'b0;
    enq_size      = lsq_pkg::MEM_BYTE;
    enq_rob_idx   = '0;
    exec_valid    = 1'b0;
    exec_rob_idx  = '0;
    exec_addr     = '0;
    exec_data     = '0;
    rob_head      = '0;
    load_valid    = 1'b0;
    load_addr     = '0;
    load_size     = lsq_pkg::MEM_BYTE;
    next_tag      = '0;
    head_reported = 1'b0;
    reported_cnt  = 0;
    applied_cnt   = 0;
    accepted_cnt  = 0;
    resp_cnt      = 0;
    resp_got      = 1'b0;
    resp_data     = '0;
    err_val       = 0;
    err_other     = 0;
    for (int i = 0; i < MEM_WORDS * 8; i++) begin
      model_mem[i] = 8'h00;
    end

    @(negedge clock);
    while (reset) begin
      @(negedge clock);
    end
    prev_free = free_slots_o;
    check_idle();
    // cleared memory reads as zero
    do_load(16'h0010, lsq_pkg::MEM_DOUBLE);

    // random store stream, then read back
    for (int k = 0; k < STREAM_BATCHES; k++) begin
      enqueue_batch(SQ_DEPTH, 0, 32);
      for (int i = 0; i < SQ_DEPTH; i++) begin
        wr_addr.push_back(b_addr[i]);
        wr_size.push_back(b_size[i]);
      end
      fill_batch(SQ_DEPTH);
      wait_drained();
      check_idle();
    end
    foreach (wr_addr[i]) begin
      do_load(wr_addr[i], wr_size[i]);
    end

    // full queue drops the extra enqueue
    enqueue_batch(SQ_DEPTH, 32, 32);
    check_val("sq_full_o", 64'(sq_full_o), 64'd1);
    check_val("free_slots_o", 64'(free_slots_o), 64'd0);
    enq_valid   = 1'b1;
    enq_size    = lsq_pkg::MEM_DOUBLE;
    enq_rob_idx = next_tag;
    step();
    enq_valid = 1'b0;
    step();
    check_val("sq_full_o", 64'(sq_full_o), 64'd1);
    check_val("free_slots_o", 64'(free_slots_o), 64'd0);
    fill_batch(SQ_DEPTH);
    wait_drained();
    check_idle();

    // loads in the low half while high half stores drain
    for (int k = 0; k < MIXED_BATCHES; k++) begin
      enqueue_batch(SQ_DEPTH, 32, 32);
      fill_batch(SQ_DEPTH);
      for (int i = 0; i < MIXED_LOADS; i++) begin
        load_size = lsq_pkg::mem_size_e'(rand_below(4));
        do_load(rand_addr(0, 32, load_size), load_size);
      end
      wait_drained();
      check_idle();
      for (int i = 0; i < SQ_DEPTH; i++) begin
        do_load(b_addr[i], b_size[i]);
      end
    end

    repeat (4) step();
    check_val("load_resp_count", 64'(resp_cnt), 64'(accepted_cnt));
    $display("errors: value=%0d other=%0d", err_val, err_other);
    if (err_val == 0 && err_other == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog sized from the operation count
  initial begin
    #(NUM_OPS * OP_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, run did not finish in %0d cycles", NUM_OPS * OP_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- build.f
design/lsq_pkg.sv
design/store_queue.sv
design/load_port.sv
design/mem_arbiter.sv
design/data_mem.sv
design/lsq_top.sv
testbench/clock_gen.sv
testbench/lsq_props.sv
testbench/lsq_tb.sv

//--- Makefile
# Verilator flow for the load/store slice

VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
